// File: alu_decoder.f
+incdir+hw
+incdir+verif
hw/alu_decoder_pkg.sv
hw/opcode_ctrl.sv
hw/base_op_decoder.sv
hw/bitmanip_op_decoder.sv
hw/operand_sel_decoder.sv
hw/alu_decoder.sv
verif/tb_alu_decoder.sv

// File: Makefile
TOOL     = verilator
TOP      = tb_alu_decoder
FILELIST = alu_decoder.f
FLAGS    = --binary --timing --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = TEST RESULT: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_alu_decoder_vectors.svh
// Decode table of the ALU decoder testbench, included inside the testbench top module
`ifndef TB_ALU_DECODER_VECTORS_SVH
`define TB_ALU_DECODER_VECTORS_SVH

// Columns: instruction, branch taken, first cycle, operator, {multicycle, mult, div},
// operand selects, use_rs3 expected one cycle later
task automatic fill_table();
  sel_ctrl_t s_inv, s_rr, s_ri, s_store, s_lui, s_auipc, s_jal;
  sel_ctrl_t s_jalr, s_br_t, s_br_n, s_fencei, s_csr, s_csri;

  s_inv    = '{OP_A_IMM,    OP_B_IMM,   IMM_A_ZERO, IMM_B_I,       OP_A_CURRPC, IMM_B_I};
  s_rr     = '{OP_A_REG_A,  OP_B_REG_B, IMM_A_ZERO, IMM_B_I,       OP_A_CURRPC, IMM_B_I};
  s_ri     = '{OP_A_REG_A,  OP_B_IMM,   IMM_A_ZERO, IMM_B_I,       OP_A_CURRPC, IMM_B_I};
  s_store  = '{OP_A_REG_A,  OP_B_IMM,   IMM_A_ZERO, IMM_B_S,       OP_A_CURRPC, IMM_B_I};
  s_lui    = '{OP_A_IMM,    OP_B_IMM,   IMM_A_ZERO, IMM_B_U,       OP_A_CURRPC, IMM_B_I};
  s_auipc  = '{OP_A_CURRPC, OP_B_IMM,   IMM_A_ZERO, IMM_B_U,       OP_A_CURRPC, IMM_B_I};
  s_jal    = '{OP_A_CURRPC, OP_B_IMM,   IMM_A_ZERO, IMM_B_INCR_PC, OP_A_CURRPC, IMM_B_J};
  s_jalr   = '{OP_A_CURRPC, OP_B_IMM,   IMM_A_ZERO, IMM_B_INCR_PC, OP_A_REG_A,  IMM_B_I};
  s_br_t   = '{OP_A_REG_A,  OP_B_REG_B, IMM_A_ZERO, IMM_B_I,       OP_A_CURRPC, IMM_B_B};
  s_br_n   = '{OP_A_REG_A,  OP_B_REG_B, IMM_A_ZERO, IMM_B_I,       OP_A_CURRPC, IMM_B_INCR_PC};
  s_fencei = '{OP_A_IMM,    OP_B_IMM,   IMM_A_ZERO, IMM_B_I,       OP_A_CURRPC, IMM_B_INCR_PC};
  s_csr    = '{OP_A_REG_A,  OP_B_IMM,   IMM_A_Z,    IMM_B_I,       OP_A_CURRPC, IMM_B_I};
  s_csri   = '{OP_A_IMM,    OP_B_IMM,   IMM_A_Z,    IMM_B_I,       OP_A_CURRPC, IMM_B_I};

  add_vector(32'h00000000, 1'b0, 1'b1, ALU_SLTU,   3'b000, s_inv,    1'b0);  // Invalid opcode
  // Register-register
  add_vector(32'h002081b3, 1'b0, 1'b1, ALU_ADD,    3'b000, s_rr,     1'b0);
  add_vector(32'h402081b3, 1'b0, 1'b1, ALU_SUB,    3'b000, s_rr,     1'b0);
  add_vector(32'h0020b1b3, 1'b0, 1'b0, ALU_SLTU,   3'b000, s_rr,     1'b0);
  add_vector(32'h0020c1b3, 1'b0, 1'b1, ALU_XOR,    3'b000, s_rr,     1'b0);
  add_vector(32'h4020d1b3, 1'b0, 1'b1, ALU_SRA,    3'b000, s_rr,     1'b0);
  // Register-immediate
  add_vector(32'h00508193, 1'b0, 1'b1, ALU_ADD,    3'b000, s_ri,     1'b0);  // addi
  add_vector(32'hfff0a193, 1'b0, 1'b1, ALU_SLT,    3'b000, s_ri,     1'b0);  // slti
  add_vector(32'h00309193, 1'b0, 1'b1, ALU_SLL,    3'b000, s_ri,     1'b0);
  add_vector(32'h0040d193, 1'b0, 1'b1, ALU_SRL,    3'b000, s_ri,     1'b0);
  add_vector(32'h4040d193, 1'b0, 1'b1, ALU_SRA,    3'b000, s_ri,     1'b0);
  // Memory, upper immediates, jumps, fences, system
  add_vector(32'h0080a183, 1'b0, 1'b1, ALU_ADD,    3'b000, s_ri,     1'b0);  // lw
  add_vector(32'h0020a423, 1'b0, 1'b1, ALU_ADD,    3'b000, s_store,  1'b0);  // sw
  add_vector(32'h123451b7, 1'b0, 1'b1, ALU_ADD,    3'b000, s_lui,    1'b0);
  add_vector(32'h12345197, 1'b0, 1'b1, ALU_ADD,    3'b000, s_auipc,  1'b0);
  add_vector(32'h008000ef, 1'b0, 1'b1, ALU_ADD,    3'b000, s_jal,    1'b0);
  add_vector(32'h000280e7, 1'b0, 1'b1, ALU_ADD,    3'b000, s_jalr,   1'b0);
  add_vector(32'h0ff0000f, 1'b0, 1'b1, ALU_ADD,    3'b000, s_ri,     1'b0);  // fence
  add_vector(32'h0000100f, 1'b0, 1'b1, ALU_ADD,    3'b000, s_fencei, 1'b0);  // fence.i
  add_vector(32'h00000073, 1'b0, 1'b1, ALU_SLTU,   3'b000, s_ri,     1'b0);  // ecall
  add_vector(32'h300091f3, 1'b0, 1'b1, ALU_SLTU,   3'b000, s_csr,    1'b0);  // csrrw
  add_vector(32'h3000d1f3, 1'b0, 1'b1, ALU_SLTU,   3'b000, s_csri,   1'b0);  // csrrwi
  // Same blt word, taken then not taken
  add_vector(32'h0020c463, 1'b1, 1'b1, ALU_LT,     3'b000, s_br_t,   1'b0);
  add_vector(32'h0020c463, 1'b0, 1'b1, ALU_LT,     3'b000, s_br_n,   1'b0);
  // M group
  add_vector(32'h022081b3, 1'b0, 1'b1, ALU_ADD,    3'b010, s_rr,     1'b0);  // mul
  add_vector(32'h022091b3, 1'b0, 1'b1, ALU_ADD,    3'b010, s_rr,     1'b0);
  add_vector(32'h0220a1b3, 1'b0, 1'b1, ALU_ADD,    3'b010, s_rr,     1'b0);
  add_vector(32'h0220b1b3, 1'b0, 1'b1, ALU_ADD,    3'b010, s_rr,     1'b0);
  add_vector(32'h0220c1b3, 1'b0, 1'b1, ALU_ADD,    3'b001, s_rr,     1'b0);  // div
  add_vector(32'h0220d1b3, 1'b0, 1'b1, ALU_ADD,    3'b001, s_rr,     1'b0);
  add_vector(32'h0220e1b3, 1'b0, 1'b1, ALU_ADD,    3'b001, s_rr,     1'b0);
  add_vector(32'h0220f1b3, 1'b0, 1'b1, ALU_ADD,    3'b001, s_rr,     1'b0);
  // Bitmanip
  add_vector(32'h0a20c1b3, 1'b0, 1'b1, ALU_MIN,    3'b000, s_rr,     1'b0);
  add_vector(32'h0820c1b3, 1'b0, 1'b1, ALU_PACK,   3'b000, s_rr,     1'b0);
  add_vector(32'h4020f1b3, 1'b0, 1'b1, ALU_ANDN,   3'b000, s_rr,     1'b0);
  add_vector(32'h2020c1b3, 1'b0, 1'b1, ALU_SH2ADD, 3'b000, s_rr,     1'b0);
  add_vector(32'h282091b3, 1'b0, 1'b1, ALU_BSET,   3'b000, s_rr,     1'b0);
  add_vector(32'h60009193, 1'b0, 1'b1, ALU_CLZ,    3'b000, s_ri,     1'b0);
  add_vector(32'h602091b3, 1'b0, 1'b1, ALU_ROL,    3'b100, s_rr,     1'b0);
  add_vector(32'h6040d193, 1'b0, 1'b1, ALU_ROR,    3'b100, s_ri,     1'b0);  // rori
  // cmov with and without first cycle, no idle cycles between
  add_vector(32'h4620d1b3, 1'b0, 1'b1, ALU_CMOV,   3'b100, s_rr,     1'b1);
  add_vector(32'h002081b3, 1'b0, 1'b1, ALU_ADD,    3'b000, s_rr,     1'b0);
  add_vector(32'h4620d1b3, 1'b0, 1'b0, ALU_CMOV,   3'b100, s_rr,     1'b0);
endtask

`endif

// File: verif/tb_alu_decoder.sv
// Testbench for the ALU decoder that runs the decode table twice and checks every output per row
module tb_alu_decoder import alu_decoder_pkg::*; ();

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 2;
  localparam int RESET_TIMEOUT = 20;
  localparam logic [31:0] SEED = 32'd43;

  // One table row whose expected rs3 use belongs to the following cycle
  typedef struct packed {
    instr_t    instr;
    logic      taken;
    logic      first;
    alu_ctrl_t exp_alu;
    sel_ctrl_t exp_sel;
    logic      exp_rs3;
  } vector_t;

  logic      clk_i;
  logic      rst_ni;
  instr_t    instr;
  logic      branch_taken;
  logic      first_cycle;
  alu_ctrl_t alu_ctrl;
  sel_ctrl_t sel_ctrl;
  logic      use_rs3;

  vector_t     table_q[$];
  logic [31:0] rand_state;
  int          alu_errors;
  int          sel_errors;
  int          rs3_errors;

  alu_decoder dut_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_i             (instr),
    .branch_taken_i      (branch_taken),
    .instr_first_cycle_i (first_cycle),
    .alu_ctrl_o          (alu_ctrl),
    .sel_ctrl_o          (sel_ctrl),
    .use_rs3_o           (use_rs3)
  );

  //////////////////////////////
  // Table and random helpers
  //////////////////////////////

  task automatic add_vector(input logic [31:0] word, input logic taken, input logic first,
                            input alu_op_e op, input logic [2:0] flags, input sel_ctrl_t sel,
                            input logic rs3);
    vector_t v;
    v.instr   = word;
    v.taken   = taken;
    v.first   = first;
    v.exp_alu = '{op, flags[2], flags[1], flags[0]};  // {multicycle, mult, div}
    v.exp_sel = sel;
    v.exp_rs3 = rs3;
    table_q.push_back(v);
  endtask

  `include "tb_alu_decoder_vectors.svh"

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Bits that carry only register numbers or immediates
  function automatic logic [31:0] free_bits(input instr_t word);
    logic [31:0] mask;
    mask = 32'h000f_8f80;  // rs1 and rd fields
    case (word.opcode)
      OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: mask = 32'hffff_ff80;  // U and J immediates
      OPCODE_LOAD, OPCODE_JALR:             mask = mask | 32'hfff0_0000;
      OPCODE_STORE, OPCODE_BRANCH:          mask = mask | 32'hfe00_0000;
      default: ;
    endcase
    return mask;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_alu_ctrl(input string tag, input alu_ctrl_t exp, input alu_ctrl_t act);
    if (act !== exp) begin
      alu_errors++;
      $display("CHECK FAILED alu_ctrl_o %s: expected 0x%h, got 0x%h", tag, exp, act);
    end
  endtask

  task automatic check_sel_ctrl(input string tag, input sel_ctrl_t exp, input sel_ctrl_t act);
    if (act !== exp) begin
      sel_errors++;
      $display("CHECK FAILED sel_ctrl_o %s: expected 0x%h, got 0x%h", tag, exp, act);
    end
  endtask

  task automatic check_rs3(input string tag, input logic exp, input logic act);
    if (act !== exp) begin
      rs3_errors++;
      $display("CHECK FAILED use_rs3_o %s: expected 0x%h, got 0x%h", tag, exp, act);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
  end

  initial begin
    int          cycles;
    int          n;
    logic        released;
    logic        prev_rs3;
    logic [31:0] word;
    vector_t     v;

    instr        = '0;
    branch_taken = 1'b0;
    first_cycle  = 1'b0;
    alu_errors   = 0;
    sel_errors   = 0;
    rs3_errors   = 0;
    rand_state   = SEED;

    fill_table();
    // Second pass repeats the rows with random register and immediate fields
    n = table_q.size();
    for (int i = 0; i < n; i++) begin
      v          = table_q[i];
      rand_state = lcg_step(rand_state);
      word       = v.instr;
      word       = (word & ~free_bits(v.instr)) | (rand_state & free_bits(v.instr));
      v.instr    = word;
      table_q.push_back(v);
    end

    cycles = 0;
    while (rst_ni !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    released = (rst_ni === 1'b1);

    if (!released) begin
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
    end else begin
      // Reset value before the first rising edge after release
      check_rs3("after reset", 1'b0, use_rs3);
      prev_rs3 = 1'b0;
      // Rows run back to back and the rs3 flag of a row shows up under the next one
      for (int i = 0; i < table_q.size(); i++) begin
        @(posedge clk_i);
        instr        <= table_q[i].instr;
        branch_taken <= table_q[i].taken;
        first_cycle  <= table_q[i].first;
        @(negedge clk_i);
        check_alu_ctrl($sformatf("row %0d", i), table_q[i].exp_alu, alu_ctrl);
        check_sel_ctrl($sformatf("row %0d", i), table_q[i].exp_sel, sel_ctrl);
        check_rs3($sformatf("row %0d", i - 1), prev_rs3, use_rs3);
        prev_rs3 = table_q[i].exp_rs3;
      end
      @(posedge clk_i);
      @(negedge clk_i);
      check_rs3($sformatf("row %0d", table_q.size() - 1), prev_rs3, use_rs3);
    end

    $display("Errors: alu_ctrl %0d, sel_ctrl %0d, use_rs3 %0d", alu_errors, sel_errors,
             rs3_errors);
    if (released && (alu_errors + sel_errors + rs3_errors) == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: hw/alu_decoder.sv
// ALU-side instruction decoder top, connects the opcode control to the operator and mux decoders
module alu_decoder import alu_decoder_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  instr_t    instr_i,
  input  logic      branch_taken_i,
  input  logic      instr_first_cycle_i,
  output alu_ctrl_t alu_ctrl_o,
  output sel_ctrl_t sel_ctrl_o,
  output logic      use_rs3_o
);

  instr_class_e instr_class;
  alu_ctrl_t    base_ctrl;
  alu_ctrl_t    bmanip_ctrl;
  logic         bmanip_hit;
  logic         bmanip_ternary;

  opcode_ctrl u_opcode_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .opcode_i         (opcode_e'(instr_i.opcode)),
    .funct3_i         (instr_i.funct3),
    .first_cycle_i    (instr_first_cycle_i),
    .base_ctrl_i      (base_ctrl),
    .bmanip_ctrl_i    (bmanip_ctrl),
    .bmanip_hit_i     (bmanip_hit),
    .bmanip_ternary_i (bmanip_ternary),
    .instr_class_o    (instr_class),
    .alu_ctrl_o       (alu_ctrl_o),
    .use_rs3_o        (use_rs3_o)
  );

  base_op_decoder u_base_op_decoder (
    .instr_class_i (instr_class),
    .funct3_i      (instr_i.funct3),
    .funct7_i      (instr_i.funct7),
    .base_ctrl_o   (base_ctrl)
  );

  bitmanip_op_decoder u_bitmanip_op_decoder (
    .instr_class_i    (instr_class),
    .funct3_i         (instr_i.funct3),
    .funct7_i         (instr_i.funct7),
    .rs2_i            (instr_i.rs2),
    .bmanip_ctrl_o    (bmanip_ctrl),
    .bmanip_hit_o     (bmanip_hit),
    .bmanip_ternary_o (bmanip_ternary)
  );

  operand_sel_decoder u_operand_sel_decoder (
    .instr_class_i  (instr_class),
    .funct3_i       (instr_i.funct3),
    .branch_taken_i (branch_taken_i),
    .sel_ctrl_o     (sel_ctrl_o)
  );

endmodule

// File: hw/operand_sel_decoder.sv
// ALU operand, immediate and branch-target mux selects per instruction class
module operand_sel_decoder import alu_decoder_pkg::*; (
  input  instr_class_e instr_class_i,
  input  funct3_t      funct3_i,
  input  logic         branch_taken_i,
  output sel_ctrl_t    sel_ctrl_o
);

  always_comb begin
    sel_ctrl_o.op_a  = OP_A_IMM;
    sel_ctrl_o.op_b  = OP_B_IMM;
    sel_ctrl_o.imm_a = IMM_A_ZERO;
    sel_ctrl_o.imm_b = IMM_B_I;
    sel_ctrl_o.bt_a  = OP_A_CURRPC;
    sel_ctrl_o.bt_b  = IMM_B_I;

    unique case (instr_class_i)
      CLASS_JAL, CLASS_JALR: begin
        // Main ALU makes the link value PC+4
        sel_ctrl_o.op_a  = OP_A_CURRPC;
        sel_ctrl_o.imm_b = IMM_B_INCR_PC;
        if (instr_class_i == CLASS_JAL) begin
          sel_ctrl_o.bt_b = IMM_B_J;
        end else begin
          sel_ctrl_o.bt_a = OP_A_REG_A;  // rs1 + I imm
        end
      end

      CLASS_BRANCH: begin
        sel_ctrl_o.op_a = OP_A_REG_A;
        sel_ctrl_o.op_b = OP_B_REG_B;
        // Not taken goes to the next instruction
        sel_ctrl_o.bt_b = branch_taken_i ? IMM_B_B : IMM_B_INCR_PC;
      end

      CLASS_STORE: begin
        sel_ctrl_o.op_a = OP_A_REG_A;
        sel_ctrl_o.op_b = OP_B_REG_B;
        if (!funct3_i[2]) begin
          sel_ctrl_o.op_b  = OP_B_IMM;
          sel_ctrl_o.imm_b = IMM_B_S;  // Offset from immediate
        end
      end

      CLASS_LOAD, CLASS_OP_IMM: sel_ctrl_o.op_a = OP_A_REG_A;

      CLASS_LUI: sel_ctrl_o.imm_b = IMM_B_U;  // Zero plus upper immediate

      CLASS_AUIPC: begin
        sel_ctrl_o.op_a  = OP_A_CURRPC;
        sel_ctrl_o.imm_b = IMM_B_U;
      end

      CLASS_OP: begin
        sel_ctrl_o.op_a = OP_A_REG_A;
        sel_ctrl_o.op_b = OP_B_REG_B;
      end

      CLASS_FENCE, CLASS_SYS_PLAIN: sel_ctrl_o.op_a = OP_A_REG_A;

      // Refetch from PC+4 through the branch-target path
      CLASS_FENCE_I: sel_ctrl_o.bt_b = IMM_B_INCR_PC;

      CLASS_CSR: begin
        sel_ctrl_o.imm_a = IMM_A_Z;                                // rs1 field as immediate
        sel_ctrl_o.op_a  = funct3_i[2] ? OP_A_IMM : OP_A_REG_A;
      end

      default: ;
    endcase
  end

endmodule

// File: hw/bitmanip_op_decoder.sv
// Balanced bitmanip operator decode with multicycle and ternary-operand flags
`include "alu_decoder_cfg.svh"

module bitmanip_op_decoder import alu_decoder_pkg::*; (
  input  instr_class_e instr_class_i,
  input  funct3_t      funct3_i,
  input  funct7_t      funct7_i,
  input  logic [4:0]   rs2_i,
  output alu_ctrl_t    bmanip_ctrl_o,
  output logic         bmanip_hit_o,
  output logic         bmanip_ternary_o
);

  always_comb begin
    bmanip_ctrl_o.operator   = ALU_SLTU;
    bmanip_ctrl_o.multicycle = 1'b0;
    bmanip_ctrl_o.mult_sel   = 1'b0;
    bmanip_ctrl_o.div_sel    = 1'b0;
    bmanip_hit_o             = 1'b0;
    bmanip_ternary_o         = 1'b0;

    if (`ENABLE_BITMANIP != 0) begin
      bmanip_hit_o = 1'b1;  // Cleared again by every default arm
      unique case (instr_class_i)

        //////////////////////////////
        // Register-immediate
        //////////////////////////////
        CLASS_OP_IMM: begin
          unique case (funct3_i)
            3'b001: begin
              unique case (funct7_i[6:2])
                5'b0_1001: bmanip_ctrl_o.operator = ALU_BCLR;
                5'b0_0101: bmanip_ctrl_o.operator = ALU_BSET;
                5'b0_1101: bmanip_ctrl_o.operator = ALU_BINV;
                5'b0_1100: begin
                  // Unary ops, selected by the rs2 field
                  unique case ({funct7_i[1:0], rs2_i})
                    7'b000_0000: bmanip_ctrl_o.operator = ALU_CLZ;
                    7'b000_0001: bmanip_ctrl_o.operator = ALU_CTZ;
                    7'b000_0010: bmanip_ctrl_o.operator = ALU_CPOP;
                    7'b000_0100: bmanip_ctrl_o.operator = ALU_SEXTB;
                    7'b000_0101: bmanip_ctrl_o.operator = ALU_SEXTH;
                    default:     bmanip_hit_o = 1'b0;
                  endcase
                end
                default: bmanip_hit_o = 1'b0;
              endcase
            end
            3'b101: begin
              if (funct7_i[1]) begin  // fsri
                bmanip_ctrl_o.operator   = ALU_FSR;
                bmanip_ctrl_o.multicycle = 1'b1;
                bmanip_ternary_o         = 1'b1;
              end else begin
                unique case (funct7_i[6:2])
                  5'b0_1001: bmanip_ctrl_o.operator = ALU_BEXT;
                  5'b0_1101: bmanip_ctrl_o.operator = ALU_GREV;
                  5'b0_0101: bmanip_ctrl_o.operator = ALU_GORC;
                  5'b0_1100: begin
                    bmanip_ctrl_o.operator   = ALU_ROR;
                    bmanip_ctrl_o.multicycle = 1'b1;
                  end
                  default: bmanip_hit_o = 1'b0;
                endcase
              end
            end
            default: bmanip_hit_o = 1'b0;
          endcase
        end

        //////////////////////////////
        // Register-register
        //////////////////////////////
        CLASS_OP: begin
          if (funct7_i[1]) begin
            // cmix, cmov, fsl, fsr all read rs3 over two cycles
            bmanip_ctrl_o.multicycle = 1'b1;
            bmanip_ternary_o         = 1'b1;
            unique case ({funct7_i[1:0], funct3_i})
              5'b11_001: bmanip_ctrl_o.operator = ALU_CMIX;
              5'b11_101: bmanip_ctrl_o.operator = ALU_CMOV;
              5'b10_001: bmanip_ctrl_o.operator = ALU_FSL;
              5'b10_101: bmanip_ctrl_o.operator = ALU_FSR;
              default: begin
                bmanip_hit_o             = 1'b0;
                bmanip_ctrl_o.multicycle = 1'b0;
                bmanip_ternary_o         = 1'b0;
              end
            endcase
          end else begin
            unique case ({funct7_i, funct3_i})
              {7'b011_0000, 3'b001}: begin
                bmanip_ctrl_o.operator   = ALU_ROL;
                bmanip_ctrl_o.multicycle = 1'b1;
              end
              {7'b011_0000, 3'b101}: begin
                bmanip_ctrl_o.operator   = ALU_ROR;
                bmanip_ctrl_o.multicycle = 1'b1;
              end
              {7'b000_0101, 3'b100}: bmanip_ctrl_o.operator = ALU_MIN;
              {7'b000_0101, 3'b110}: bmanip_ctrl_o.operator = ALU_MAX;
              {7'b000_0101, 3'b101}: bmanip_ctrl_o.operator = ALU_MINU;
              {7'b000_0101, 3'b111}: bmanip_ctrl_o.operator = ALU_MAXU;
              {7'b000_0100, 3'b100}: bmanip_ctrl_o.operator = ALU_PACK;
              {7'b010_0100, 3'b100}: bmanip_ctrl_o.operator = ALU_PACKU;
              {7'b000_0100, 3'b111}: bmanip_ctrl_o.operator = ALU_PACKH;
              {7'b010_0000, 3'b100}: bmanip_ctrl_o.operator = ALU_XNOR;
              {7'b010_0000, 3'b110}: bmanip_ctrl_o.operator = ALU_ORN;
              {7'b010_0000, 3'b111}: bmanip_ctrl_o.operator = ALU_ANDN;
              {7'b001_0000, 3'b010}: bmanip_ctrl_o.operator = ALU_SH1ADD;
              {7'b001_0000, 3'b100}: bmanip_ctrl_o.operator = ALU_SH2ADD;
              {7'b001_0000, 3'b110}: bmanip_ctrl_o.operator = ALU_SH3ADD;
              {7'b010_0100, 3'b001}: bmanip_ctrl_o.operator = ALU_BCLR;
              {7'b001_0100, 3'b001}: bmanip_ctrl_o.operator = ALU_BSET;
              {7'b011_0100, 3'b001}: bmanip_ctrl_o.operator = ALU_BINV;
              {7'b010_0100, 3'b101}: bmanip_ctrl_o.operator = ALU_BEXT;
              {7'b011_0100, 3'b101}: bmanip_ctrl_o.operator = ALU_GREV;
              {7'b001_0100, 3'b101}: bmanip_ctrl_o.operator = ALU_GORC;
              default:               bmanip_hit_o = 1'b0;
            endcase
          end
        end

        default: bmanip_hit_o = 1'b0;
      endcase
    end
  end

endmodule

// File: hw/base_op_decoder.sv
// RV32I and M operator decode, with the multiply and divide data-path selects
`include "alu_decoder_cfg.svh"

module base_op_decoder import alu_decoder_pkg::*; (
  input  instr_class_e instr_class_i,
  input  funct3_t      funct3_i,
  input  funct7_t      funct7_i,
  output alu_ctrl_t    base_ctrl_o
);

  always_comb begin
    base_ctrl_o.operator   = ALU_SLTU;
    base_ctrl_o.multicycle = 1'b0;
    base_ctrl_o.mult_sel   = 1'b0;
    base_ctrl_o.div_sel    = 1'b0;

    unique case (instr_class_i)
      // Address, upper immediate and link value all add
      CLASS_JAL, CLASS_JALR, CLASS_LOAD, CLASS_STORE, CLASS_LUI, CLASS_AUIPC,
      CLASS_FENCE, CLASS_FENCE_I: base_ctrl_o.operator = ALU_ADD;

      CLASS_BRANCH: begin
        unique case (funct3_i)
          3'b000:  base_ctrl_o.operator = ALU_EQ;
          3'b001:  base_ctrl_o.operator = ALU_NE;
          3'b100:  base_ctrl_o.operator = ALU_LT;
          3'b101:  base_ctrl_o.operator = ALU_GE;
          3'b110:  base_ctrl_o.operator = ALU_LTU;
          3'b111:  base_ctrl_o.operator = ALU_GEU;
          default: ;
        endcase
      end

      CLASS_OP_IMM: begin
        unique case (funct3_i)
          3'b000: base_ctrl_o.operator = ALU_ADD;
          3'b010: base_ctrl_o.operator = ALU_SLT;
          3'b011: base_ctrl_o.operator = ALU_SLTU;
          3'b100: base_ctrl_o.operator = ALU_XOR;
          3'b110: base_ctrl_o.operator = ALU_OR;
          3'b111: base_ctrl_o.operator = ALU_AND;
          3'b001: begin
            // Without bitmanip the upper immediate bits are not looked at
            if ((`ENABLE_BITMANIP == 0) || (funct7_i[6:2] == 5'b0_0000)) begin
              base_ctrl_o.operator = ALU_SLL;
            end
          end
          3'b101: begin
            if (funct7_i[6:2] == 5'b0_0000) begin
              base_ctrl_o.operator = ALU_SRL;
            end else if (funct7_i[6:2] == 5'b0_1000) begin
              base_ctrl_o.operator = ALU_SRA;
            end
          end
          default: ;
        endcase
      end

      CLASS_OP: begin
        if (funct7_i == 7'b000_0001) begin
          // M group, the ALU only sees an add
          base_ctrl_o.operator = ALU_ADD;
          base_ctrl_o.mult_sel = (`ENABLE_MULDIV != 0) && !funct3_i[2];
          base_ctrl_o.div_sel  = (`ENABLE_MULDIV != 0) && funct3_i[2];
        end else if (!funct7_i[1]) begin  // Ternary group stays at default
          unique case ({funct7_i, funct3_i})
            {7'b000_0000, 3'b000}: base_ctrl_o.operator = ALU_ADD;
            {7'b010_0000, 3'b000}: base_ctrl_o.operator = ALU_SUB;
            {7'b000_0000, 3'b010}: base_ctrl_o.operator = ALU_SLT;
            {7'b000_0000, 3'b011}: base_ctrl_o.operator = ALU_SLTU;
            {7'b000_0000, 3'b100}: base_ctrl_o.operator = ALU_XOR;
            {7'b000_0000, 3'b110}: base_ctrl_o.operator = ALU_OR;
            {7'b000_0000, 3'b111}: base_ctrl_o.operator = ALU_AND;
            {7'b000_0000, 3'b001}: base_ctrl_o.operator = ALU_SLL;
            {7'b000_0000, 3'b101}: base_ctrl_o.operator = ALU_SRL;
            {7'b010_0000, 3'b101}: base_ctrl_o.operator = ALU_SRA;
            default: ;
          endcase
        end
      end

      default: ;
    endcase
  end

endmodule

// File: hw/opcode_ctrl.sv
// Opcode classification, operator merge and the registered rs3-use flag of the ALU decoder
module opcode_ctrl import alu_decoder_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  opcode_e      opcode_i,
  input  funct3_t      funct3_i,
  input  logic         first_cycle_i,
  input  alu_ctrl_t    base_ctrl_i,
  input  alu_ctrl_t    bmanip_ctrl_i,
  input  logic         bmanip_hit_i,
  input  logic         bmanip_ternary_i,
  output instr_class_e instr_class_o,
  output alu_ctrl_t    alu_ctrl_o,
  output logic         use_rs3_o
);

  logic use_rs3_d;
  logic use_rs3_q;

  //////////////////////////////
  // Instruction class
  //////////////////////////////

  always_comb begin
    instr_class_o = CLASS_INVALID;
    unique case (opcode_i)
      OPCODE_JAL:    instr_class_o = CLASS_JAL;
      OPCODE_JALR:   instr_class_o = CLASS_JALR;
      OPCODE_BRANCH: instr_class_o = CLASS_BRANCH;
      OPCODE_LOAD:   instr_class_o = CLASS_LOAD;
      OPCODE_STORE:  instr_class_o = CLASS_STORE;
      OPCODE_LUI:    instr_class_o = CLASS_LUI;
      OPCODE_AUIPC:  instr_class_o = CLASS_AUIPC;
      OPCODE_OP_IMM: instr_class_o = CLASS_OP_IMM;
      OPCODE_OP:     instr_class_o = CLASS_OP;
      OPCODE_MISC_MEM: begin
        if (funct3_i == 3'b000) begin
          instr_class_o = CLASS_FENCE;
        end else if (funct3_i == 3'b001) begin
          instr_class_o = CLASS_FENCE_I;
        end
      end
      // Any non-zero funct3 touches a CSR
      OPCODE_SYSTEM: instr_class_o = (funct3_i == 3'b000) ? CLASS_SYS_PLAIN : CLASS_CSR;
      default: ;
    endcase
  end

  // Bitmanip result wins on a hit
  assign alu_ctrl_o = bmanip_hit_i ? bmanip_ctrl_i : base_ctrl_i;

  //////////////////////////////
  // rs3 use, one cycle ahead
  //////////////////////////////

  assign use_rs3_d = bmanip_ternary_i & first_cycle_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      use_rs3_q <= 1'b0;
    end else begin
      use_rs3_q <= use_rs3_d;
    end
  end

  assign use_rs3_o = use_rs3_q;

endmodule

// File: hw/alu_decoder_pkg.sv
// Shared types of the ALU decoder: instruction overlay, operator and mux encodings, control bundles
`include "alu_decoder_cfg.svh"

package alu_decoder_pkg;

  // Instruction word, fields at their bit positions
  typedef struct packed {
    logic [`INSTR_W-1:25] funct7;
    logic [24:20]         rs2;
    logic [19:15]         rs1;
    logic [14:12]         funct3;
    logic [11:7]          rd;
    logic [6:0]           opcode;
  } instr_t;

  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_AUIPC    = 7'h17,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_BRANCH   = 7'h63,
    OPCODE_JALR     = 7'h67,
    OPCODE_JAL      = 7'h6f,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  typedef enum logic [3:0] {
    CLASS_JAL, CLASS_JALR, CLASS_BRANCH, CLASS_LOAD, CLASS_STORE,
    CLASS_LUI, CLASS_AUIPC, CLASS_OP_IMM, CLASS_OP, CLASS_FENCE,
    CLASS_FENCE_I, CLASS_SYS_PLAIN, CLASS_CSR, CLASS_INVALID
  } instr_class_e;

  typedef enum logic [5:0] {
    ALU_ADD, ALU_SUB,
    ALU_XOR, ALU_OR, ALU_AND, ALU_XNOR, ALU_ORN, ALU_ANDN, // Logic, plain and negated
    ALU_SRA, ALU_SRL, ALU_SLL, ALU_ROR, ALU_ROL,           // Shifts and rotates
    ALU_GREV, ALU_GORC,
    ALU_LT, ALU_LTU, ALU_GE, ALU_GEU, ALU_EQ, ALU_NE,      // Comparisons
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
    ALU_PACK, ALU_PACKU, ALU_PACKH,
    ALU_SEXTB, ALU_SEXTH,
    ALU_CLZ, ALU_CTZ, ALU_CPOP,
    ALU_SLT, ALU_SLTU,
    ALU_CMOV, ALU_CMIX, ALU_FSL, ALU_FSR,                  // Ternary, need rs3
    ALU_BSET, ALU_BCLR, ALU_BINV, ALU_BEXT,                // Single-bit ops
    ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic {IMM_A_Z, IMM_A_ZERO} imm_a_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  // Operator plus the static data-path selects
  typedef struct packed {
    alu_op_e operator;
    logic    multicycle;
    logic    mult_sel;
    logic    div_sel;
  } alu_ctrl_t;

  typedef struct packed {
    op_a_sel_e  op_a;
    op_b_sel_e  op_b;
    imm_a_sel_e imm_a;
    imm_b_sel_e imm_b;
    op_a_sel_e  bt_a;  // Branch-target ALU operands
    imm_b_sel_e bt_b;
  } sel_ctrl_t;

endpackage

// File: hw/alu_decoder_cfg.svh
// Feature switches and field widths for the ALU decoder, included by the package and decoders
`ifndef ALU_DECODER_CFG_SVH
`define ALU_DECODER_CFG_SVH

//////////////////////////////
// Feature enables
//////////////////////////////

// Balanced bitmanip subset
`define ENABLE_BITMANIP 1

// Multiply and divide data-path selects
`define ENABLE_MULDIV 1

// Instruction word
`define INSTR_W 32

`endif
